// ==== hdl/rp_pkg.sv ====
// rp_pkg: shared widths, bus regions, register map and address view for the board top
package rp_pkg;

  ////////////////////////////////////////
  // system bus geometry
  ////////////////////////////////////////

  localparam int unsigned SYS_DW = 32;  // data word
  localparam int unsigned SYS_RW = 3;   // region select, 8 regions
  localparam int unsigned SYS_OW = 20;  // offset inside a region
  localparam int unsigned SYS_AW = SYS_RW + SYS_OW;

  // region/offset split of the bus address
  typedef struct packed {
    logic [SYS_RW-1:0] region;  // top bits
    logic [SYS_OW-1:0] offset;
  } sys_addr_s;

  // same 23 bits, flat or split
  typedef union packed {
    logic [SYS_AW-1:0] flat;
    sys_addr_s         fld;
  } sys_addr_u;

  // mapped regions, everything else errors
  localparam logic [SYS_RW-1:0] REG_HK  = 3'd0;
  localparam logic [SYS_RW-1:0] REG_AMS = 3'd4;

  ////////////////////////////////////////
  // datapath widths
  ////////////////////////////////////////

  localparam int unsigned ADC_DW = 14;  // raw adc word
  localparam int unsigned PDM_DW = 8;   // pdm setting, range 256
  localparam int unsigned LED_W  = 8;

  ////////////////////////////////////////
  // housekeeping map
  ////////////////////////////////////////

  localparam logic [SYS_DW-1:0] HK_ID = 32'h5250_4144;  // board id, read only

  localparam logic [SYS_OW-1:0] HK_OFS_ID    = 20'h00;
  localparam logic [SYS_OW-1:0] HK_OFS_P_DIR = 20'h10;  // 1 = drive pin
  localparam logic [SYS_OW-1:0] HK_OFS_N_DIR = 20'h14;
  localparam logic [SYS_OW-1:0] HK_OFS_P_OUT = 20'h18;
  localparam logic [SYS_OW-1:0] HK_OFS_N_OUT = 20'h1C;
  localparam logic [SYS_OW-1:0] HK_OFS_P_IN  = 20'h20;  // synchronized pins
  localparam logic [SYS_OW-1:0] HK_OFS_N_IN  = 20'h24;
  localparam logic [SYS_OW-1:0] HK_OFS_LED   = 20'h30;

  // ams map, channel k at PDM0 + 4*k
  localparam logic [SYS_OW-1:0] AMS_OFS_PDM0 = 20'h20;

endpackage : rp_pkg

// ==== hdl/sys_bus_decoder.sv ====
// system bus decoder: registers one request, steers it to a region slave, muxes the reply
module sys_bus_decoder (
  input  logic                        adc_clk_01,
  input  logic                        rst_n_i,
  // master side
  input  rp_pkg::sys_addr_u           sys_addr_i,
  input  logic [rp_pkg::SYS_DW-1:0]   sys_wdata_i,
  input  logic                        sys_wen_i,
  input  logic                        sys_ren_i,
  output logic [rp_pkg::SYS_DW-1:0]   sys_rdata_o,
  output logic                        sys_ack_o,
  output logic                        sys_err_o,
  // slave side, shared offset/data
  output logic [rp_pkg::SYS_OW-1:0]   reg_offset_o,
  output logic [rp_pkg::SYS_DW-1:0]   reg_wdata_o,
  output logic                        hk_wen_o,
  output logic                        hk_ren_o,
  input  logic [rp_pkg::SYS_DW-1:0]   hk_rdata_i,
  input  logic                        hk_ack_i,
  output logic                        ams_wen_o,
  output logic                        ams_ren_o,
  input  logic [rp_pkg::SYS_DW-1:0]   ams_rdata_i,
  input  logic                        ams_ack_i
);

  rp_pkg::sys_addr_u           req_addr_q;     // captured address
  logic [rp_pkg::SYS_DW-1:0]   req_wdata_q;
  logic                        req_wen_q;
  logic                        req_ren_q;
  logic                        req_stb;        // request stage busy
  logic                        hk_sel;
  logic                        ams_sel;
  logic [rp_pkg::SYS_RW-1:0]   pend_region_q;  // who answers next
  logic                        pend_q;         // access waiting for ack
  logic                        err_q;          // own error reply

  ////////////////////////////////////////
  // request stage
  ////////////////////////////////////////

  always_ff @(posedge adc_clk_01) begin
    if (!rst_n_i) begin
      req_wen_q <= 1'b0;
      req_ren_q <= 1'b0;
    end else begin
      req_wen_q <= sys_wen_i;
      req_ren_q <= sys_ren_i;
    end
  end

  // payload only, loaded with the strobe
  always_ff @(posedge adc_clk_01) begin
    if (sys_wen_i || sys_ren_i) begin
      req_addr_q.flat <= sys_addr_i.flat;
      req_wdata_q     <= sys_wdata_i;
    end
  end

  assign req_stb = req_wen_q | req_ren_q;
  assign hk_sel  = (req_addr_q.fld.region == rp_pkg::REG_HK);
  assign ams_sel = (req_addr_q.fld.region == rp_pkg::REG_AMS);

  assign reg_offset_o = req_addr_q.fld.offset;
  assign reg_wdata_o  = req_wdata_q;
  assign hk_wen_o     = req_wen_q & hk_sel;
  assign hk_ren_o     = req_ren_q & hk_sel;
  assign ams_wen_o    = req_wen_q & ams_sel;
  assign ams_ren_o    = req_ren_q & ams_sel;

  ////////////////////////////////////////
  // reply stage
  ////////////////////////////////////////

  always_ff @(posedge adc_clk_01) begin
    if (!rst_n_i) begin
      pend_region_q <= '0;
      pend_q        <= 1'b0;
      err_q         <= 1'b0;
    end else begin
      err_q <= req_stb & ~(hk_sel | ams_sel);  // unmapped, answer ourselves
      if (req_stb) begin
        pend_region_q <= req_addr_q.fld.region;
        pend_q        <= 1'b1;
      end else if (sys_ack_o) begin
        pend_q <= 1'b0;
      end
    end
  end

  // reply mux follows the region that was strobed
  always_comb begin
    case (pend_region_q)
      rp_pkg::REG_HK: begin
        sys_rdata_o = hk_rdata_i;
        sys_ack_o   = hk_ack_i;
      end
      rp_pkg::REG_AMS: begin
        sys_rdata_o = ams_rdata_i;
        sys_ack_o   = ams_ack_i;
      end
      default: begin
        sys_rdata_o = '0;     // errors read zero
        sys_ack_o   = err_q;
      end
    endcase
  end

  assign sys_err_o = err_q;

  // master protocol, one strobe kind per cycle
  a_one_strobe : assert property (@(posedge adc_clk_01) disable iff (!rst_n_i)
    !(sys_wen_i && sys_ren_i))
    else $error("sys bus: wen and ren high together");

  // slave reply only for an access we sent
  a_ack_pending : assert property (@(posedge adc_clk_01) disable iff (!rst_n_i)
    sys_ack_o |-> pend_q)
    else $error("sys bus: ack without pending access");

endmodule : sys_bus_decoder

// ==== hdl/adc_sample_fmt.sv ====
// adc sample formatter: negative-slope offset binary to two's complement, two register stages
module adc_sample_fmt #(
  parameter int unsigned ADC_N = 4  // channels
) (
  input  logic                                    adc_clk_01,
  input  logic                                    rst_n_i,
  input  logic [ADC_N-1:0][rp_pkg::ADC_DW-1:0]    adc_dat_i,  // raw, already parallel
  output logic signed [rp_pkg::ADC_DW-1:0]        adc_dat_o [ADC_N]
);

  logic signed [rp_pkg::ADC_DW-1:0] fmt_q [ADC_N];  // stage one

  ////////////////////////////////////////
  // two stage pipe, per channel
  ////////////////////////////////////////

  always_ff @(posedge adc_clk_01) begin
    if (!rst_n_i) begin
      for (int ch = 0; ch < ADC_N; ch++) begin
        fmt_q[ch]     <= '0;
        adc_dat_o[ch] <= '0;
      end
    end else begin
      for (int ch = 0; ch < ADC_N; ch++) begin
        // keep msb, flip the rest
        fmt_q[ch]     <= {adc_dat_i[ch][rp_pkg::ADC_DW-1],
                          ~adc_dat_i[ch][rp_pkg::ADC_DW-2:0]};
        adc_dat_o[ch] <= fmt_q[ch];  // output stage
      end
    end
  end

endmodule : adc_sample_fmt

// ==== hdl/hk_regs.sv ====
// housekeeping registers: id word, leds, expansion connector direction, output and input
module hk_regs #(
  parameter int unsigned EXP_W = 11  // pins per side
) (
  input  logic                        adc_clk_01,
  input  logic                        rst_n_i,
  // region slave port
  input  logic [rp_pkg::SYS_OW-1:0]   reg_offset_i,
  input  logic [rp_pkg::SYS_DW-1:0]   reg_wdata_i,
  input  logic                        reg_wen_i,
  input  logic                        reg_ren_i,
  output logic [rp_pkg::SYS_DW-1:0]   reg_rdata_o,
  output logic                        reg_ack_o,
  // leds
  output logic [rp_pkg::LED_W-1:0]    led_o,
  // expansion connector
  input  logic [EXP_W-1:0]            exp_p_i,
  input  logic [EXP_W-1:0]            exp_n_i,
  output logic [EXP_W-1:0]            exp_p_o,
  output logic [EXP_W-1:0]            exp_n_o,
  output logic [EXP_W-1:0]            exp_p_oe_o,
  output logic [EXP_W-1:0]            exp_n_oe_o
);

  logic [rp_pkg::LED_W-1:0]    led_q;
  logic [EXP_W-1:0]            p_dir_q, n_dir_q;   // 1 = output
  logic [EXP_W-1:0]            p_out_q, n_out_q;
  logic [EXP_W-1:0]            p_meta_q, n_meta_q; // sync stage 1
  logic [EXP_W-1:0]            p_sync_q, n_sync_q; // sync stage 2
  logic [rp_pkg::SYS_DW-1:0]   rd_mux;

  ////////////////////////////////////////
  // writable registers
  ////////////////////////////////////////

  always_ff @(posedge adc_clk_01) begin
    if (!rst_n_i) begin
      led_q   <= '0;
      p_dir_q <= '0;  // all pins input
      n_dir_q <= '0;
      p_out_q <= '0;
      n_out_q <= '0;
    end else if (reg_wen_i) begin
      case (reg_offset_i)
        rp_pkg::HK_OFS_P_DIR: p_dir_q <= reg_wdata_i[EXP_W-1:0];
        rp_pkg::HK_OFS_N_DIR: n_dir_q <= reg_wdata_i[EXP_W-1:0];
        rp_pkg::HK_OFS_P_OUT: p_out_q <= reg_wdata_i[EXP_W-1:0];
        rp_pkg::HK_OFS_N_OUT: n_out_q <= reg_wdata_i[EXP_W-1:0];
        rp_pkg::HK_OFS_LED:   led_q   <= reg_wdata_i[rp_pkg::LED_W-1:0];
        default: ;  // id, inputs and holes ignore writes
      endcase
    end
  end

  assign led_o      = led_q;
  assign exp_p_o    = p_out_q;
  assign exp_n_o    = n_out_q;
  assign exp_p_oe_o = p_dir_q;
  assign exp_n_oe_o = n_dir_q;

  ////////////////////////////////////////
  // pin input synchronizer
  ////////////////////////////////////////

  always_ff @(posedge adc_clk_01) begin
    p_meta_q <= exp_p_i;
    n_meta_q <= exp_n_i;
    p_sync_q <= p_meta_q;
    n_sync_q <= n_meta_q;
  end

  ////////////////////////////////////////
  // readback
  ////////////////////////////////////////

  always_comb begin
    rd_mux = '0;  // unknown offsets read zero
    case (reg_offset_i)
      rp_pkg::HK_OFS_ID:    rd_mux = rp_pkg::HK_ID;
      rp_pkg::HK_OFS_P_DIR: rd_mux[EXP_W-1:0] = p_dir_q;
      rp_pkg::HK_OFS_N_DIR: rd_mux[EXP_W-1:0] = n_dir_q;
      rp_pkg::HK_OFS_P_OUT: rd_mux[EXP_W-1:0] = p_out_q;
      rp_pkg::HK_OFS_N_OUT: rd_mux[EXP_W-1:0] = n_out_q;
      rp_pkg::HK_OFS_P_IN:  rd_mux[EXP_W-1:0] = p_sync_q;
      rp_pkg::HK_OFS_N_IN:  rd_mux[EXP_W-1:0] = n_sync_q;
      rp_pkg::HK_OFS_LED:   rd_mux[rp_pkg::LED_W-1:0] = led_q;
      default: ;
    endcase
  end

  // zero except in the ack cycle of a read
  always_ff @(posedge adc_clk_01) begin
    reg_rdata_o <= reg_ren_i ? rd_mux : '0;
  end

  always_ff @(posedge adc_clk_01) begin
    if (!rst_n_i) begin
      reg_ack_o <= 1'b0;
    end else begin
      reg_ack_o <= reg_wen_i | reg_ren_i;  // every strobe answered
    end
  end

endmodule : hk_regs

// ==== hdl/ams_regs.sv ====
// analog mixed signal registers: pdm channel settings with readback
module ams_regs #(
  parameter int unsigned PDM_N = 4  // pdm channels
) (
  input  logic                                  adc_clk_01,
  input  logic                                  rst_n_i,
  input  logic [rp_pkg::SYS_OW-1:0]             reg_offset_i,
  input  logic [rp_pkg::SYS_DW-1:0]             reg_wdata_i,
  input  logic                                  reg_wen_i,
  input  logic                                  reg_ren_i,
  output logic [rp_pkg::SYS_DW-1:0]             reg_rdata_o,
  output logic                                  reg_ack_o,
  output logic [PDM_N-1:0][rp_pkg::PDM_DW-1:0]  pdm_cfg_o
);

  logic [PDM_N-1:0]            hit;     // offset matches channel
  logic [rp_pkg::SYS_DW-1:0]   rd_mux;

  for (genvar k = 0; k < PDM_N; k++) begin : g_ch
    localparam logic [rp_pkg::SYS_OW-1:0] CH_OFS =
      rp_pkg::AMS_OFS_PDM0 + rp_pkg::SYS_OW'(4 * k);

    assign hit[k] = (reg_offset_i == CH_OFS);

    always_ff @(posedge adc_clk_01) begin
      if (!rst_n_i) begin
        pdm_cfg_o[k] <= '0;  // outputs idle low
      end else if (reg_wen_i && hit[k]) begin
        pdm_cfg_o[k] <= reg_wdata_i[rp_pkg::PDM_DW-1:0];  // low byte only
      end
    end
  end

  // zero-extended readback
  always_comb begin
    rd_mux = '0;
    for (int k = 0; k < PDM_N; k++) begin
      if (hit[k]) rd_mux[rp_pkg::PDM_DW-1:0] = pdm_cfg_o[k];
    end
  end

  always_ff @(posedge adc_clk_01) begin
    reg_rdata_o <= reg_ren_i ? rd_mux : '0;
  end

  always_ff @(posedge adc_clk_01) begin
    if (!rst_n_i) reg_ack_o <= 1'b0;
    else          reg_ack_o <= reg_wen_i | reg_ren_i;
  end

endmodule : ams_regs

// ==== hdl/pdm_gen.sv ====
// pdm generator: per channel accumulator, carry out gives duty of setting/256
module pdm_gen #(
  parameter int unsigned PDM_N = 4
) (
  input  logic                                  adc_clk_01,
  input  logic                                  rst_n_i,
  input  logic [PDM_N-1:0][rp_pkg::PDM_DW-1:0]  pdm_cfg_i,
  output logic [PDM_N-1:0]                      pdm_o
);

  ////////////////////////////////////////
  // one accumulator per channel
  ////////////////////////////////////////

  for (genvar k = 0; k < PDM_N; k++) begin : g_ch
    logic [rp_pkg::PDM_DW-1:0] acc_q;
    logic [rp_pkg::PDM_DW:0]   sum;  // carry on top

    assign sum = {1'b0, acc_q} + {1'b0, pdm_cfg_i[k]};

    always_ff @(posedge adc_clk_01) begin
      if (!rst_n_i) begin
        acc_q    <= '0;
        pdm_o[k] <= 1'b0;
      end else begin
        acc_q    <= sum[rp_pkg::PDM_DW-1:0];  // wraps mod 256
        pdm_o[k] <= sum[rp_pkg::PDM_DW];      // one pulse per wrap
      end
    end

    // zero setting must not leak pulses from the accumulator
    a_zero_quiet : assert property (@(posedge adc_clk_01) disable iff (!rst_n_i)
      (pdm_cfg_i[k] == '0) |=> !pdm_o[k])
      else $error("pdm ch %0d: pulse with zero setting", k);
  end

endmodule : pdm_gen

// ==== hdl/rp_top.sv ====
// board top, fast clock side: bus decoder, housekeeping, ams, pdm and adc formatting
module rp_top #(
  parameter int unsigned EXP_W = 11,  // expansion pins per side
  parameter int unsigned ADC_N = 4,   // adc channels
  parameter int unsigned PDM_N = 4    // pdm channels
) (
  input  logic                                   adc_clk_01,
  input  logic                                   rst_n_i,
  // system bus
  input  rp_pkg::sys_addr_u                      sys_addr_i,
  input  logic [rp_pkg::SYS_DW-1:0]              sys_wdata_i,
  input  logic                                   sys_wen_i,
  input  logic                                   sys_ren_i,
  output logic [rp_pkg::SYS_DW-1:0]              sys_rdata_o,
  output logic                                   sys_ack_o,
  output logic                                   sys_err_o,
  // adc
  input  logic [ADC_N-1:0][rp_pkg::ADC_DW-1:0]   adc_dat_i,
  output logic signed [rp_pkg::ADC_DW-1:0]       adc_dat_o [ADC_N],
  // leds and expansion connector
  output logic [rp_pkg::LED_W-1:0]               led_o,
  input  logic [EXP_W-1:0]                       exp_p_i,
  input  logic [EXP_W-1:0]                       exp_n_i,
  output logic [EXP_W-1:0]                       exp_p_o,
  output logic [EXP_W-1:0]                       exp_n_o,
  output logic [EXP_W-1:0]                       exp_p_oe_o,
  output logic [EXP_W-1:0]                       exp_n_oe_o,
  // pdm analog outputs
  output logic [PDM_N-1:0]                       pdm_o
);

  logic [rp_pkg::SYS_OW-1:0]              reg_offset;  // shared by all slaves
  logic [rp_pkg::SYS_DW-1:0]              reg_wdata;
  logic                                   hk_wen, hk_ren, hk_ack;
  logic                                   ams_wen, ams_ren, ams_ack;
  logic [rp_pkg::SYS_DW-1:0]              hk_rdata, ams_rdata;
  logic [PDM_N-1:0][rp_pkg::PDM_DW-1:0]   pdm_cfg;

  ////////////////////////////////////////
  // bus decoder
  ////////////////////////////////////////

  sys_bus_decoder i_dec (
    .adc_clk_01   (adc_clk_01),
    .rst_n_i      (rst_n_i),
    .sys_addr_i   (sys_addr_i),
    .sys_wdata_i  (sys_wdata_i),
    .sys_wen_i    (sys_wen_i),
    .sys_ren_i    (sys_ren_i),
    .sys_rdata_o  (sys_rdata_o),
    .sys_ack_o    (sys_ack_o),
    .sys_err_o    (sys_err_o),
    .reg_offset_o (reg_offset),
    .reg_wdata_o  (reg_wdata),
    .hk_wen_o     (hk_wen),       // region 0
    .hk_ren_o     (hk_ren),
    .hk_rdata_i   (hk_rdata),
    .hk_ack_i     (hk_ack),
    .ams_wen_o    (ams_wen),      // region 4
    .ams_ren_o    (ams_ren),
    .ams_rdata_i  (ams_rdata),
    .ams_ack_i    (ams_ack)
  );

  ////////////////////////////////////////
  // housekeeping
  ////////////////////////////////////////

  hk_regs #(.EXP_W(EXP_W)) i_hk (
    .adc_clk_01   (adc_clk_01),
    .rst_n_i      (rst_n_i),
    .reg_offset_i (reg_offset),
    .reg_wdata_i  (reg_wdata),
    .reg_wen_i    (hk_wen),
    .reg_ren_i    (hk_ren),
    .reg_rdata_o  (hk_rdata),
    .reg_ack_o    (hk_ack),
    .led_o        (led_o),
    .exp_p_i      (exp_p_i),
    .exp_n_i      (exp_n_i),
    .exp_p_o      (exp_p_o),
    .exp_n_o      (exp_n_o),
    .exp_p_oe_o   (exp_p_oe_o),
    .exp_n_oe_o   (exp_n_oe_o)
  );

  ////////////////////////////////////////
  // pdm settings and generators
  ////////////////////////////////////////

  ams_regs #(.PDM_N(PDM_N)) i_ams (
    .adc_clk_01   (adc_clk_01),
    .rst_n_i      (rst_n_i),
    .reg_offset_i (reg_offset),
    .reg_wdata_i  (reg_wdata),
    .reg_wen_i    (ams_wen),
    .reg_ren_i    (ams_ren),
    .reg_rdata_o  (ams_rdata),
    .reg_ack_o    (ams_ack),
    .pdm_cfg_o    (pdm_cfg)
  );

  pdm_gen #(.PDM_N(PDM_N)) i_pdm (
    .adc_clk_01   (adc_clk_01),
    .rst_n_i      (rst_n_i),
    .pdm_cfg_i    (pdm_cfg),
    .pdm_o        (pdm_o)
  );

  // adc words to two's complement
  adc_sample_fmt #(.ADC_N(ADC_N)) i_adc (
    .adc_clk_01   (adc_clk_01),
    .rst_n_i      (rst_n_i),
    .adc_dat_i    (adc_dat_i),
    .adc_dat_o    (adc_dat_o)
  );

endmodule : rp_top

// ==== dv/tb_clk_gen.sv ====
// testbench clock and reset source, 100 ns clock with a synchronous reset pulse
module tb_clk_gen #(
  parameter int unsigned RST_CYC = 8  // reset length in clocks
) (
  output logic clk_o,
  output logic rst_n_o
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;  // 100 ns period
  end

  // release on a falling edge, like any other stimulus
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYC) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule : tb_clk_gen

// ==== dv/rp_top_tb.sv ====
// board top testbench: random bus, adc and pin stimulus checked against a reference model
module rp_top_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned EXP_W    = 11;
  localparam int unsigned ADC_N    = 4;
  localparam int unsigned PDM_N    = 4;
  localparam int unsigned ACK_WAIT = 16;  // cycles until an access is given up
  localparam int unsigned RST_WAIT = 32;

  logic                                  adc_clk_01;
  logic                                  rst_n;
  rp_pkg::sys_addr_u                     sys_addr;
  logic [rp_pkg::SYS_DW-1:0]             sys_wdata;
  logic                                  sys_wen;
  logic                                  sys_ren;
  logic [rp_pkg::SYS_DW-1:0]             sys_rdata;
  logic                                  sys_ack;
  logic                                  sys_err;
  logic [ADC_N-1:0][rp_pkg::ADC_DW-1:0]  adc_dat_i;
  logic signed [rp_pkg::ADC_DW-1:0]      adc_dat_o [ADC_N];
  logic [rp_pkg::LED_W-1:0]              led_o;
  logic [EXP_W-1:0]                      exp_p_i, exp_n_i;
  logic [EXP_W-1:0]                      exp_p_o, exp_n_o;
  logic [EXP_W-1:0]                      exp_p_oe_o, exp_n_oe_o;
  logic [PDM_N-1:0]                      pdm_o;

  // reference model of the writable registers
  logic [rp_pkg::LED_W-1:0]   led_m;
  logic [EXP_W-1:0]           p_dir_m, n_dir_m, p_out_m, n_out_m;
  logic [rp_pkg::PDM_DW-1:0]  pdm_m [PDM_N];

  integer seed;      // bus and pin stimulus
  integer adc_seed;  // adc samples, own stream
  int unsigned n_val_err   = 0;
  int unsigned n_other_err = 0;

  tb_clk_gen #(.RST_CYC(8)) i_clk (
    .clk_o   (adc_clk_01),
    .rst_n_o (rst_n)
  );

  rp_top #(.EXP_W(EXP_W), .ADC_N(ADC_N), .PDM_N(PDM_N)) UUT (
    .adc_clk_01  (adc_clk_01),
    .rst_n_i     (rst_n),
    .sys_addr_i  (sys_addr),
    .sys_wdata_i (sys_wdata),
    .sys_wen_i   (sys_wen),
    .sys_ren_i   (sys_ren),
    .sys_rdata_o (sys_rdata),
    .sys_ack_o   (sys_ack),
    .sys_err_o   (sys_err),
    .adc_dat_i   (adc_dat_i),
    .adc_dat_o   (adc_dat_o),
    .led_o       (led_o),
    .exp_p_i     (exp_p_i),
    .exp_n_i     (exp_n_i),
    .exp_p_o     (exp_p_o),
    .exp_n_o     (exp_n_o),
    .exp_p_oe_o  (exp_p_oe_o),
    .exp_n_oe_o  (exp_n_oe_o),
    .pdm_o       (pdm_o)
  );

  ////////////////////////////////////////
  // model helpers
  ////////////////////////////////////////

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    n_val_err++;
    $display("FAILED %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
  endtask

  // negative slope adc word, msb stays and the rest flips
  function automatic logic [rp_pkg::ADC_DW-1:0] fmt_expect(
    input logic [rp_pkg::ADC_DW-1:0] raw);
    logic [rp_pkg::ADC_DW-1:0] mask;
    mask = '1;
    mask[rp_pkg::ADC_DW-1] = 1'b0;
    return raw ^ mask;
  endfunction

  function automatic logic [rp_pkg::SYS_DW-1:0] hk_expect(
    input logic [rp_pkg::SYS_OW-1:0] offset);
    logic [rp_pkg::SYS_DW-1:0] val;
    val = '0;  // holes read zero
    case (offset)
      rp_pkg::HK_OFS_ID:    val = rp_pkg::HK_ID;
      rp_pkg::HK_OFS_P_DIR: val[EXP_W-1:0] = p_dir_m;
      rp_pkg::HK_OFS_N_DIR: val[EXP_W-1:0] = n_dir_m;
      rp_pkg::HK_OFS_P_OUT: val[EXP_W-1:0] = p_out_m;
      rp_pkg::HK_OFS_N_OUT: val[EXP_W-1:0] = n_out_m;
      rp_pkg::HK_OFS_P_IN:  val[EXP_W-1:0] = exp_p_i;  // pins held long enough
      rp_pkg::HK_OFS_N_IN:  val[EXP_W-1:0] = exp_n_i;
      rp_pkg::HK_OFS_LED:   val[rp_pkg::LED_W-1:0] = led_m;
      default: ;
    endcase
    return val;
  endfunction

  function automatic logic [rp_pkg::SYS_DW-1:0] ams_expect(
    input logic [rp_pkg::SYS_OW-1:0] offset);
    logic [rp_pkg::SYS_DW-1:0] val;
    val = '0;
    for (int k = 0; k < PDM_N; k++) begin
      if (offset == rp_pkg::AMS_OFS_PDM0 + 4 * k) val[rp_pkg::PDM_DW-1:0] = pdm_m[k];
    end
    return val;
  endfunction

  task automatic model_write(input logic [rp_pkg::SYS_RW-1:0] region,
                             input logic [rp_pkg::SYS_OW-1:0] offset,
                             input logic [rp_pkg::SYS_DW-1:0] wdata);
    if (region == rp_pkg::REG_HK) begin
      case (offset)
        rp_pkg::HK_OFS_P_DIR: p_dir_m = wdata[EXP_W-1:0];
        rp_pkg::HK_OFS_N_DIR: n_dir_m = wdata[EXP_W-1:0];
        rp_pkg::HK_OFS_P_OUT: p_out_m = wdata[EXP_W-1:0];
        rp_pkg::HK_OFS_N_OUT: n_out_m = wdata[EXP_W-1:0];
        rp_pkg::HK_OFS_LED:   led_m   = wdata[rp_pkg::LED_W-1:0];
        default: ;  // read only or hole
      endcase
    end else if (region == rp_pkg::REG_AMS) begin
      for (int k = 0; k < PDM_N; k++) begin
        if (offset == rp_pkg::AMS_OFS_PDM0 + 4 * k) pdm_m[k] = wdata[rp_pkg::PDM_DW-1:0];
      end
    end
  endtask

  // mapped offsets plus a hole and one past the map
  function automatic logic [rp_pkg::SYS_OW-1:0] hk_offset_at(input int unsigned idx);
    case (idx)
      0: return rp_pkg::HK_OFS_ID;
      1: return rp_pkg::HK_OFS_P_DIR;
      2: return rp_pkg::HK_OFS_N_DIR;
      3: return rp_pkg::HK_OFS_P_OUT;
      4: return rp_pkg::HK_OFS_N_OUT;
      5: return rp_pkg::HK_OFS_P_IN;
      6: return rp_pkg::HK_OFS_N_IN;
      7: return rp_pkg::HK_OFS_LED;
      8: return 20'h04;
      default: return 20'h40;
    endcase
  endfunction

  task automatic check_outputs();
    if (led_o !== led_m) report_mismatch("led_o", led_o, led_m);
    if (exp_p_o !== p_out_m) report_mismatch("exp_p_o", exp_p_o, p_out_m);
    if (exp_n_o !== n_out_m) report_mismatch("exp_n_o", exp_n_o, n_out_m);
    if (exp_p_oe_o !== p_dir_m) report_mismatch("exp_p_oe_o", exp_p_oe_o, p_dir_m);
    if (exp_n_oe_o !== n_dir_m) report_mismatch("exp_n_oe_o", exp_n_oe_o, n_dir_m);
  endtask

  ////////////////////////////////////////
  // bus master
  ////////////////////////////////////////

  // called just after a falling edge, returns at the ack falling edge
  task automatic bus_access(input  logic                      wr,
                            input  logic [rp_pkg::SYS_RW-1:0] region,
                            input  logic [rp_pkg::SYS_OW-1:0] offset,
                            input  logic [rp_pkg::SYS_DW-1:0] wdata,
                            output logic [rp_pkg::SYS_DW-1:0] rdata,
                            output logic                      err);
    int unsigned n;
    logic        done;
    n = 0;
    done = 1'b0;
    rdata = '0;
    err = 1'b0;
    sys_addr.flat = {region, offset};
    sys_wdata = wdata;
    sys_wen = wr;
    sys_ren = !wr;
    while (!done && n < ACK_WAIT) begin
      @(negedge adc_clk_01);
      n++;
      if (n == 1) begin
        sys_wen = 1'b0;  // single cycle strobe
        sys_ren = 1'b0;
      end
      done = sys_ack;
    end
    if (!done) begin
      n_other_err++;
      $display("no ack within %0d cycles, region %0d offset 0x%h", ACK_WAIT, region, offset);
    end else begin
      if (n != 2) begin
        n_other_err++;
        $display("ack came %0d cycles after the strobe instead of 2", n);
      end
      rdata = sys_rdata;
      err = sys_err;
    end
  endtask

  ////////////////////////////////////////
  // adc stream, runs beside the bus
  ////////////////////////////////////////

  initial begin : adc_stim
    logic [ADC_N-1:0][rp_pkg::ADC_DW-1:0] hist0, hist1;  // last two samples driven
    logic [rp_pkg::ADC_DW-1:0]            exp_word;
    int unsigned                          n;
    int unsigned                          depth;
    adc_seed = 61;
    adc_dat_i = '0;
    hist0 = '0;
    hist1 = '0;
    n = 0;
    depth = 0;
    while (rst_n !== 1'b1 && n < RST_WAIT) begin
      @(posedge adc_clk_01);
      n++;
    end
    @(negedge adc_clk_01);
    forever begin
      if (depth >= 2) begin
        for (int ch = 0; ch < ADC_N; ch++) begin
          exp_word = fmt_expect(hist1[ch]);  // driven two edges ago
          if (adc_dat_o[ch] !== exp_word)
            report_mismatch($sformatf("adc_dat_o[%0d]", ch), $unsigned(adc_dat_o[ch]),
                            exp_word);
        end
      end
      hist1 = hist0;
      for (int ch = 0; ch < ADC_N; ch++) hist0[ch] = $random(adc_seed);
      adc_dat_i = hist0;
      if (depth < 2) depth++;
      @(negedge adc_clk_01);
    end
  end

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin : main_seq
    logic [rp_pkg::SYS_DW-1:0] rdata, wdata, exp_rd;
    logic                      err, wr;
    logic [rp_pkg::SYS_RW-1:0] region;
    logic [rp_pkg::SYS_OW-1:0] offset;
    int unsigned               n;
    int unsigned               pdm_cnt [PDM_N];
    seed = 61;
    sys_addr = '0;
    sys_wdata = '0;
    sys_wen = 1'b0;
    sys_ren = 1'b0;
    exp_p_i = '0;
    exp_n_i = '0;
    led_m = '0;
    p_dir_m = '0;
    n_dir_m = '0;
    p_out_m = '0;
    n_out_m = '0;
    for (int k = 0; k < PDM_N; k++) pdm_m[k] = '0;

    n = 0;
    while (rst_n !== 1'b1 && n < RST_WAIT) begin
      @(posedge adc_clk_01);
      n++;
    end
    if (rst_n !== 1'b1) begin
      n_other_err++;
      $display("reset was never released");
    end
    @(negedge adc_clk_01);

    // reset state, nothing accessed yet
    if (sys_ack !== 1'b0) report_mismatch("sys_ack_o", sys_ack, 0);
    if (pdm_o !== '0) report_mismatch("pdm_o", pdm_o, 0);
    check_outputs();

    // random register traffic on both mapped regions
    exp_p_i = $random(seed);
    exp_n_i = $random(seed);
    repeat (3) @(negedge adc_clk_01);  // let the pin sync settle
    for (int i = 0; i < 200; i++) begin
      wr = ($random(seed) & 1) != 0;
      region = (($random(seed) & 1) != 0) ? rp_pkg::REG_AMS : rp_pkg::REG_HK;
      if (region == rp_pkg::REG_HK) offset = hk_offset_at($unsigned($random(seed)) % 10);
      else offset = rp_pkg::AMS_OFS_PDM0 + 20'(4 * ($unsigned($random(seed)) % 6));
      wdata = $random(seed);
      if (wr) exp_rd = '0;  // writes return zero data
      else if (region == rp_pkg::REG_HK) exp_rd = hk_expect(offset);
      else exp_rd = ams_expect(offset);
      bus_access(wr, region, offset, wdata, rdata, err);
      if (wr) model_write(region, offset, wdata);
      if (err !== 1'b0) report_mismatch("sys_err_o", err, 0);
      if (rdata !== exp_rd) report_mismatch("sys_rdata_o", rdata, exp_rd);
      check_outputs();
    end

    // expansion inputs through the synchronizer
    for (int i = 0; i < 8; i++) begin
      exp_p_i = $random(seed);
      exp_n_i = $random(seed);
      repeat (3) @(negedge adc_clk_01);
      bus_access(1'b0, rp_pkg::REG_HK, rp_pkg::HK_OFS_P_IN, '0, rdata, err);
      if (rdata !== 32'(exp_p_i)) report_mismatch("sys_rdata_o p_in", rdata, exp_p_i);
      bus_access(1'b0, rp_pkg::REG_HK, rp_pkg::HK_OFS_N_IN, '0, rdata, err);
      if (rdata !== 32'(exp_n_i)) report_mismatch("sys_rdata_o n_in", rdata, exp_n_i);
    end

    // unmapped regions answer with an error
    for (int i = 0; i < 24; i++) begin
      do region = $random(seed);
      while (region == rp_pkg::REG_HK || region == rp_pkg::REG_AMS);
      offset = hk_offset_at($unsigned($random(seed)) % 10);  // live hk offsets, wrong region
      wr = ($random(seed) & 1) != 0;
      bus_access(wr, region, offset, $random(seed), rdata, err);
      if (err !== 1'b1) report_mismatch("sys_err_o", err, 1);
      if (rdata !== '0) report_mismatch("sys_rdata_o", rdata, 0);
      check_outputs();  // nothing may change
    end

    // pdm duty over a full accumulator period
    for (int round = 0; round < 2; round++) begin
      for (int k = 0; k < PDM_N; k++) begin
        wdata = $random(seed);
        offset = rp_pkg::AMS_OFS_PDM0 + 20'(4 * k);
        bus_access(1'b1, rp_pkg::REG_AMS, offset, wdata, rdata, err);
        model_write(rp_pkg::REG_AMS, offset, wdata);
      end
      repeat (2) @(negedge adc_clk_01);  // new setting reaches the carry
      for (int k = 0; k < PDM_N; k++) pdm_cnt[k] = 0;
      repeat (256) begin
        @(negedge adc_clk_01);
        for (int k = 0; k < PDM_N; k++) if (pdm_o[k]) pdm_cnt[k]++;
      end
      for (int k = 0; k < PDM_N; k++) begin
        if (pdm_cnt[k] != pdm_m[k])
          report_mismatch($sformatf("pdm_o[%0d] high count", k), pdm_cnt[k], pdm_m[k]);
      end
    end

    $display("value errors %0d, other errors %0d", n_val_err, n_other_err);
    if (n_val_err == 0 && n_other_err == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule : rp_top_tb

// ==== vlog.f ====
hdl/rp_pkg.sv
hdl/sys_bus_decoder.sv
hdl/adc_sample_fmt.sv
hdl/hk_regs.sv
hdl/ams_regs.sv
hdl/pdm_gen.sv
hdl/rp_top.sv
dv/tb_clk_gen.sv
dv/rp_top_tb.sv
